// File: filelist.f
src/fetch_pkg.sv
src/axi_lite_pkg.sv
src/fetch_ifs.sv
src/inst_fetch.sv
src/inst_sram.sv
src/fetch_queue.sv
src/inst_decode.sv
src/fetch_top.sv
bench/tb_clock.sv
bench/fetch_checker.sv
bench/tb_top.sv

// File: bench/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    // Retires per test set the timeout budget
    localparam int SEQ_RETIRES   = 16;
    localparam int JAL_RETIRES   = 12;
    localparam int HOLD_RETIRES  = 24;
    localparam int FAULT_RETIRES = 6;
    localparam int RST_RETIRES   = 4;
    localparam int TIMEOUT_CYCLES =
        (SEQ_RETIRES + JAL_RETIRES + HOLD_RETIRES + FAULT_RETIRES + RST_RETIRES) * 20;
    localparam int RESET_CYCLES = 3;

    logic                          M_AXI_ACLK;
    logic                          ifu_rst;
    logic                          i_hold;
    logic                          i_load_en;
    axi_lite_pkg::axi_addr_t       i_load_addr;
    fetch_pkg::word_t              i_load_data;
    logic                          o_retire_valid;
    fetch_pkg::pc_t                o_retire_pc;
    fetch_pkg::word_t              o_retire_ins;
    fetch_pkg::inst_class_e        o_retire_class;
    logic                          o_retire_fault;
    fetch_pkg::pc_t                o_retire_next_pc;

    // Program image as the model sees it
    fetch_pkg::word_t prog [axi_lite_pkg::MEM_WORDS];
    logic [31:0]      lcg_state = 32'd6791;
    string            test_name = "init";
    int               mismatch_count = 0;
    int               other_count = 0;
    int               run_cycles = 0;

    tb_clock u_clock (.o_clk(M_AXI_ACLK));

    fetch_top uut
    (
        .M_AXI_ACLK       (M_AXI_ACLK),
        .ifu_rst          (ifu_rst),
        .i_hold           (i_hold),
        .i_load_en        (i_load_en),
        .i_load_addr      (i_load_addr),
        .i_load_data      (i_load_data),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_ins     (o_retire_ins),
        .o_retire_class   (o_retire_class),
        .o_retire_fault   (o_retire_fault),
        .o_retire_next_pc (o_retire_next_pc)
    );

    bind inst_fetch fetch_checker u_checker
    (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .ifu_rst      (ifu_rst),
        .i_arvalid    (axi.arvalid),
        .i_arready    (axi.arready),
        .i_araddr     (axi.araddr),
        .i_rvalid     (axi.rvalid),
        .i_rready     (axi.rready),
        .i_push_valid (push.valid),
        .i_state      (state_q)
    );

    // ----------------------------------------------------------
    // Timeout on cycles spent running the tests
    // ----------------------------------------------------------
    always @(posedge M_AXI_ACLK)
    begin
        if (ifu_rst && !i_load_en)
            run_cycles <= run_cycles + 1;
    end

    initial
    begin
        wait (run_cycles >= TIMEOUT_CYCLES);
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // addi x1, x0, addr so every word tells its own address
    function automatic fetch_pkg::word_t fill_word(input logic [31:0] addr);
        return {addr[11:0], 5'd0, 3'b000, 5'd1, fetch_pkg::OPC_OPIMM};
    endfunction

    // Random word with any opcode but JAL
    function automatic fetch_pkg::word_t plain_word();
        logic [31:0] r;
        logic [6:0]  opc;
        r = lcg_next();
        case (r[1:0])
            2'd0:    opc = fetch_pkg::OPC_OPIMM;
            2'd1:    opc = fetch_pkg::OPC_LUI;
            2'd2:    opc = 7'b0110011;
            default: opc = 7'b0000011;
        endcase
        return {r[31:7], opc};
    endfunction

    // jal x1 with a byte offset
    function automatic fetch_pkg::word_t jal_word(input int offset);
        logic [20:0] off;
        off = offset[20:0];
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, fetch_pkg::OPC_JAL};
    endfunction

    task automatic fill_program();
        for (int i = 0; i < axi_lite_pkg::MEM_WORDS; i++)
            prog[i] = fill_word(i * 4);
    endtask

    // Forward JAL, backward JAL, then a second forward JAL
    task automatic jump_program();
        fill_program();
        prog[2] = jal_word(16);
        prog[7] = jal_word(-16);
        prog[5] = jal_word(20);
    endtask

    // ----------------------------------------------------------
    // Reference model of one retire
    // ----------------------------------------------------------
    function automatic void predict(input fetch_pkg::pc_t pc, output fetch_pkg::word_t ins,
                                    output logic fault, output fetch_pkg::inst_class_e cls,
                                    output fetch_pkg::pc_t next_pc);
        logic [31:0] idx;
        logic [20:0] off;
        idx = pc >> 2;
        fault = (idx >= axi_lite_pkg::MEM_WORDS);
        ins = fault ? '0 : prog[idx];
        cls = fetch_pkg::OTHER;
        if (!fault)
        begin
            case (ins[6:0])
                fetch_pkg::OPC_JAL:   cls = fetch_pkg::JAL;
                fetch_pkg::OPC_OPIMM: cls = fetch_pkg::OPIMM;
                fetch_pkg::OPC_LUI:   cls = fetch_pkg::LOAD_UPPER;
                default:              cls = fetch_pkg::OTHER;
            endcase
        end
        next_pc = pc + 32'd4;
        if (cls == fetch_pkg::JAL)
        begin
            // imm[20|10:1|11|19:12] back into offset order
            off[20]    = ins[31];
            off[10:1]  = ins[30:21];
            off[11]    = ins[20];
            off[19:12] = ins[19:12];
            off[0]     = 1'b0;
            next_pc = pc + {{11{off[20]}}, off};
        end
    endfunction

    task automatic check_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            mismatch_count++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic check_quiet(input string when);
        assert (o_retire_valid === 1'b0)
        else
        begin
            other_count++;
            $display("Test %s: retire valid was high %s", test_name, when);
        end
    endtask

    // Loads the whole memory and then pulses reset
    task automatic load_and_reset();
        @(negedge M_AXI_ACLK);
        i_hold = 1'b0;
        for (int i = 0; i < axi_lite_pkg::MEM_WORDS; i++)
        begin
            i_load_en   = 1'b1;
            i_load_addr = i * 4;
            i_load_data = prog[i];
            @(negedge M_AXI_ACLK);
        end
        i_load_en = 1'b0;
        ifu_rst   = 1'b0;
        repeat (RESET_CYCLES)
        begin
            @(negedge M_AXI_ACLK);
            check_quiet("during reset");
        end
        ifu_rst = 1'b1;
    endtask

    // Walks the model path alongside the retires
    task automatic collect_retires(input int count, input bit use_hold);
        fetch_pkg::pc_t         model_pc;
        fetch_pkg::word_t       e_ins;
        logic                   e_fault;
        fetch_pkg::inst_class_e e_cls;
        fetch_pkg::pc_t         e_next;
        logic [31:0]            r;
        int                     got;
        model_pc = fetch_pkg::RESET_PC;
        got = 0;
        while (got < count)
        begin
            @(negedge M_AXI_ACLK);
            if (o_retire_valid)
            begin
                predict(model_pc, e_ins, e_fault, e_cls, e_next);
                check_value("pc", model_pc, o_retire_pc);
                check_value("ins", e_ins, o_retire_ins);
                check_value("class", 32'(e_cls), 32'(o_retire_class));
                check_value("fault", 32'(e_fault), 32'(o_retire_fault));
                check_value("next_pc", e_next, o_retire_next_pc);
                model_pc = e_next;
                got++;
            end
            if (use_hold)
            begin
                // Mostly held so the queue fills and room falls
                r = lcg_next();
                i_hold = (r[18:16] != 3'd0);
            end
        end
        i_hold = 1'b0;
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic test_sequential();
        test_name = "sequential";
        fill_program();
        for (int i = 0; i < SEQ_RETIRES; i++)
            prog[i] = plain_word();
        load_and_reset();
        collect_retires(SEQ_RETIRES, 1'b0);
    endtask

    task automatic test_jal_redirect();
        test_name = "jal_redirect";
        jump_program();
        load_and_reset();
        collect_retires(JAL_RETIRES, 1'b0);
    endtask

    // Same path as without stalls
    task automatic test_back_pressure();
        test_name = "back_pressure";
        jump_program();
        load_and_reset();
        collect_retires(HOLD_RETIRES, 1'b1);
    endtask

    // JAL from 4 lands at MEM_WORDS * 4
    task automatic test_fault();
        test_name = "fault";
        fill_program();
        prog[1] = jal_word(axi_lite_pkg::MEM_WORDS * 4 - 4);
        load_and_reset();
        collect_retires(FAULT_RETIRES, 1'b0);
    endtask

    task automatic test_reset();
        test_name = "reset";
        fill_program();
        load_and_reset();
        @(negedge M_AXI_ACLK);
        check_quiet("in the cycle after reset");
        collect_retires(RST_RETIRES, 1'b0);
    endtask

    initial
    begin
        ifu_rst     = 1'b0;
        i_hold      = 1'b0;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;

        test_sequential();
        test_jal_redirect();
        test_back_pressure();
        test_fault();
        test_reset();

        $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, other_count, uut.u_fetch.u_checker.fail_count);
        if ((mismatch_count == 0) && (other_count == 0) &&
            (uut.u_fetch.u_checker.fail_count == 0))
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: bench/fetch_checker.sv
`timescale 1ns/10ps

// Read channel and push rules of inst_fetch bound into every instance
module fetch_checker
(
    input logic                    M_AXI_ACLK,
    input logic                    ifu_rst,
    input logic                    i_arvalid,
    input logic                    i_arready,
    input axi_lite_pkg::axi_addr_t i_araddr,
    input logic                    i_rvalid,
    input logic                    i_rready,
    input logic                    i_push_valid,
    input fetch_pkg::fetch_state_e i_state
);

    logic [1:0] in_flight_q;
    int         fail_count = 0;

    // Reads accepted on AR but not yet answered on R
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
            in_flight_q <= '0;
        else if ((i_arvalid && i_arready) && !(i_rvalid && i_rready))
            in_flight_q <= in_flight_q + 1'b1;
        else if (!(i_arvalid && i_arready) && (i_rvalid && i_rready))
            in_flight_q <= in_flight_q - 1'b1;
    end

    // ----------------------------------------------------------
    // AR channel
    // ----------------------------------------------------------

    // ARVALID only falls after a handshake
    ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        $fell(i_arvalid) |-> $past(i_arready))
    else
    begin
        $error("ARVALID fell before ARREADY");
        fail_count++;
    end

    // Address held from AR issue until the R beat
    ar_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        (i_arvalid || (in_flight_q != '0)) |=> $stable(i_araddr))
    else
    begin
        $error("ARADDR changed while a read was outstanding");
        fail_count++;
    end

    // Push completes an accepted read and never comes from IDLE
    push_state: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        i_push_valid |-> (in_flight_q == 2'd1))
    else
    begin
        $error("Entry pushed without a read outstanding");
        fail_count++;
    end

    // Nothing outstanding in IDLE or when a new address goes out
    one_read: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        (i_arvalid || (i_state == fetch_pkg::IDLE)) |-> (in_flight_q == '0))
    else
    begin
        $error("Second read issued while one is in flight");
        fail_count++;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/10ps

// Free running clock for the testbench
module tb_clock
(
    output logic o_clk
);

    // Half of the 40 ns period
    localparam real HALF_PERIOD = 20.0;

    initial
    begin
        o_clk = 1'b0;
        forever
            #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/10ps

module fetch_top
(
    input  logic                    M_AXI_ACLK,
    input  logic                    ifu_rst,
    input  logic                    i_hold,
    input  logic                    i_load_en,
    input  axi_lite_pkg::axi_addr_t i_load_addr,
    input  fetch_pkg::word_t        i_load_data,
    output logic                    o_retire_valid,
    output fetch_pkg::pc_t          o_retire_pc,
    output fetch_pkg::word_t        o_retire_ins,
    output fetch_pkg::inst_class_e  o_retire_class,
    output logic                    o_retire_fault,
    output fetch_pkg::pc_t          o_retire_next_pc
);

    logic           room;
    logic           redirect;
    fetch_pkg::pc_t redirect_pc;

    // ----------------------------------------------------------
    // Links between the blocks
    // ----------------------------------------------------------
    axi_rd_if      axi_link ();
    fetch_entry_if push_link ();
    fetch_entry_if pop_link ();

    // Read master with the PC
    inst_fetch u_fetch
    (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .ifu_rst       (ifu_rst),
        .axi           (axi_link.master),
        .push          (push_link.producer),
        .i_room        (room),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc)
    );

    // Instruction memory, read only slave
    inst_sram u_sram
    (
        .M_AXI_ACLK  (M_AXI_ACLK),
        .ifu_rst     (ifu_rst),
        .axi         (axi_link.slave),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data)
    );

    // Fetched entries, emptied on redirect
    fetch_queue u_queue
    (
        .M_AXI_ACLK (M_AXI_ACLK),
        .ifu_rst    (ifu_rst),
        .push       (push_link.consumer),
        .pop        (pop_link.producer),
        .o_room     (room),
        .i_flush    (redirect)
    );

    inst_decode u_decode
    (
        .M_AXI_ACLK       (M_AXI_ACLK),
        .ifu_rst          (ifu_rst),
        .pop              (pop_link.consumer),
        .i_hold           (i_hold),
        .o_redirect       (redirect),
        .o_redirect_pc    (redirect_pc),
        .o_retire_valid   (o_retire_valid),
        .o_retire_pc      (o_retire_pc),
        .o_retire_ins     (o_retire_ins),
        .o_retire_class   (o_retire_class),
        .o_retire_fault   (o_retire_fault),
        .o_retire_next_pc (o_retire_next_pc)
    );

endmodule

// File: src/inst_decode.sv
`timescale 1ns/10ps

module inst_decode
(
    input  logic                   M_AXI_ACLK,
    input  logic                   ifu_rst,
    fetch_entry_if.consumer        pop,
    input  logic                   i_hold,
    output logic                   o_redirect,
    output fetch_pkg::pc_t         o_redirect_pc,
    output logic                   o_retire_valid,
    output fetch_pkg::pc_t         o_retire_pc,
    output fetch_pkg::word_t       o_retire_ins,
    output fetch_pkg::inst_class_e o_retire_class,
    output logic                   o_retire_fault,
    output fetch_pkg::pc_t         o_retire_next_pc
);

    fetch_pkg::inst_class_e cls;
    fetch_pkg::pc_t         j_imm;
    fetch_pkg::pc_t         next_pc;
    logic                   pop_fire;

    // Stall on hold
    assign pop.ready = !i_hold;
    assign pop_fire  = pop.valid && pop.ready;

    // ----------------------------------------------------------
    // Opcode class, a faulted entry is always OTHER
    // ----------------------------------------------------------
    always_comb
    begin
        cls = fetch_pkg::OTHER;
        if (!pop.fault)
        begin
            case (pop.ins[6:0])
                fetch_pkg::OPC_JAL:   cls = fetch_pkg::JAL;
                fetch_pkg::OPC_OPIMM: cls = fetch_pkg::OPIMM;
                fetch_pkg::OPC_LUI:   cls = fetch_pkg::LOAD_UPPER;
                default:              cls = fetch_pkg::OTHER;
            endcase
        end
    end

    // J-type immediate, sign extended, bit 0 always zero
    assign j_imm = {{11{pop.ins[31]}}, pop.ins[31], pop.ins[19:12], pop.ins[20],
                    pop.ins[30:21], 1'b0};

    // Jump target or fall through
    assign next_pc = (cls == fetch_pkg::JAL) ? pop.pc + j_imm : pop.pc + fetch_pkg::INST_BYTES;

    // Control outputs, redirect pulses with the JAL retire
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
        begin
            o_retire_valid <= 1'b0;
            o_redirect     <= 1'b0;
        end
        else
        begin
            o_retire_valid <= pop_fire;
            o_redirect     <= pop_fire && (cls == fetch_pkg::JAL);
        end
    end

    // Retire payload
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (pop_fire)
        begin
            o_retire_pc      <= pop.pc;
            o_retire_ins     <= pop.ins;
            o_retire_class   <= cls;
            o_retire_fault   <= pop.fault;
            o_retire_next_pc <= next_pc;
            o_redirect_pc    <= next_pc;
        end
    end

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue
(
    input  logic            M_AXI_ACLK,
    input  logic            ifu_rst,
    fetch_entry_if.consumer push,
    fetch_entry_if.producer pop,
    output logic            o_room,
    input  logic            i_flush
);

    fetch_pkg::pc_t                   pc_mem    [fetch_pkg::QUEUE_DEPTH];
    fetch_pkg::word_t                 ins_mem   [fetch_pkg::QUEUE_DEPTH];
    logic                             fault_mem [fetch_pkg::QUEUE_DEPTH];
    logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [fetch_pkg::QUEUE_PTR_W:0]   count_q;
    logic                             push_en;
    logic                             pop_en;

    // Accepts unless all entries are held
    assign push.ready = (count_q != fetch_pkg::QUEUE_DEPTH);
    assign push_en    = push.valid && push.ready;

    // Head entry is hidden while a flush is under way
    assign pop.valid = (count_q != '0) && !i_flush;
    assign pop.pc    = pc_mem[rd_ptr_q];
    assign pop.ins   = ins_mem[rd_ptr_q];
    assign pop.fault = fault_mem[rd_ptr_q];
    assign pop_en    = pop.valid && pop.ready;

    // Room for one more read in flight
    assign o_room = (count_q < fetch_pkg::QUEUE_DEPTH - 1);

    // Entry storage
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (push_en)
        begin
            pc_mem[wr_ptr_q]    <= push.pc;
            ins_mem[wr_ptr_q]   <= push.ins;
            fault_mem[wr_ptr_q] <= push.fault;
        end
    end

    // Pointers and count
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        // Flush empties the queue
        else if (i_flush)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_en)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_en)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push_en && !pop_en)
                count_q <= count_q + 1'b1;
            else if (pop_en && !push_en)
                count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: src/inst_sram.sv
`timescale 1ns/10ps

module inst_sram
(
    input  logic                    M_AXI_ACLK,
    input  logic                    ifu_rst,
    axi_rd_if.slave                 axi,
    input  logic                    i_load_en,
    input  axi_lite_pkg::axi_addr_t i_load_addr,
    input  fetch_pkg::word_t        i_load_data
);

    fetch_pkg::word_t                         mem [axi_lite_pkg::MEM_WORDS];
    axi_lite_pkg::axi_addr_t                  addr_q;
    logic                                     busy_q;
    logic [axi_lite_pkg::LAT_CNT_W-1:0]       lat_cnt_q;
    logic                                     rvalid_q;
    fetch_pkg::word_t                         rdata_q;
    axi_lite_pkg::axi_resp_t                  rresp_q;
    logic                                     ar_fire;
    logic                                     in_range;

    // Idle slave always takes an address
    assign axi.arready = !busy_q;
    assign ar_fire     = axi.arvalid && axi.arready;

    // Word index must fall inside the array
    assign in_range = (addr_q[axi_lite_pkg::AXI_ADDR_WIDTH-1:2] < axi_lite_pkg::MEM_WORDS);

    assign axi.rvalid = rvalid_q;
    assign axi.rdata  = rdata_q;
    assign axi.rresp  = rresp_q;

    // ----------------------------------------------------------
    // Load port, testbench writes the program here
    // ----------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (i_load_en && (i_load_addr[axi_lite_pkg::AXI_ADDR_WIDTH-1:2] < axi_lite_pkg::MEM_WORDS))
            mem[i_load_addr[axi_lite_pkg::MEM_IDX_W+1:2]] <= i_load_data;
    end

    // Accepted address
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (ar_fire)
            addr_q <= axi.araddr;
    end

    // ----------------------------------------------------------
    // Read response after MEM_LATENCY cycles
    // ----------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
        begin
            busy_q    <= 1'b0;
            lat_cnt_q <= '0;
            rvalid_q  <= 1'b0;
        end
        else if (ar_fire)
        begin
            busy_q    <= 1'b1;
            lat_cnt_q <= axi_lite_pkg::LAT_CNT_W'(axi_lite_pkg::MEM_LATENCY - 1);
        end
        else if (busy_q && (lat_cnt_q != '0))
        begin
            lat_cnt_q <= lat_cnt_q - 1'b1;
        end
        else if (busy_q && !rvalid_q)
        begin
            rvalid_q <= 1'b1;
        end
        // Beat taken, back to idle
        else if (rvalid_q && axi.rready)
        begin
            rvalid_q <= 1'b0;
            busy_q   <= 1'b0;
        end
    end

    // Data and response, out of range gives DECERR with zero data
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (busy_q && (lat_cnt_q == '0) && !rvalid_q)
        begin
            rdata_q <= in_range ? mem[addr_q[axi_lite_pkg::MEM_IDX_W+1:2]] : '0;
            rresp_q <= in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_DECERR;
        end
    end

endmodule

// File: src/inst_fetch.sv
`timescale 1ns/10ps

module inst_fetch
(
    input  logic            M_AXI_ACLK,
    input  logic            ifu_rst,
    axi_rd_if.master        axi,
    fetch_entry_if.producer push,
    input  logic            i_room,
    input  logic            i_redirect,
    input  fetch_pkg::pc_t  i_redirect_pc
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::pc_t          pc_q;
    axi_lite_pkg::axi_addr_t araddr_q;
    logic                    discard_q;
    logic                    start_rd;
    logic                    r_fire;

    // ----------------------------------------------------------
    // Handshake decode
    // ----------------------------------------------------------

    // New read only with queue room and no redirect pending
    assign start_rd = (state_q == fetch_pkg::IDLE) && i_room && !i_redirect;

    // R beat accepted, rready is a level in DATA
    assign r_fire = axi.rvalid && axi.rready;

    // AR channel
    assign axi.araddr  = araddr_q;
    assign axi.arvalid = (state_q == fetch_pkg::ADDR);

    // R channel
    assign axi.rready = (state_q == fetch_pkg::DATA);

    // ----------------------------------------------------------
    // Push side, valid only in the R handshake cycle
    // ----------------------------------------------------------

    // Stale data after a redirect never reaches the queue
    assign push.valid = r_fire && !discard_q && !i_redirect;
    assign push.pc    = araddr_q;
    assign push.ins   = axi.rdata;
    // DECERR or any other non-OKAY code marks the entry
    assign push.fault = (axi.rresp != axi_lite_pkg::RESP_OKAY);

    // ----------------------------------------------------------
    // Read master FSM
    // ----------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
        begin
            state_q <= fetch_pkg::IDLE;
        end
        else
        begin
            case (state_q)
                fetch_pkg::IDLE:
                begin
                    if (start_rd)
                        state_q <= fetch_pkg::ADDR;
                end
                // Hold ARVALID until the slave takes the address
                fetch_pkg::ADDR:
                begin
                    if (axi.arready)
                        state_q <= fetch_pkg::DATA;
                end
                fetch_pkg::DATA:
                begin
                    if (r_fire)
                        state_q <= fetch_pkg::IDLE;
                end
                default:
                begin
                    state_q <= fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // Address captured once per read, stable while ARVALID waits
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (start_rd)
            araddr_q <= pc_q;
    end

    // PC update, redirect wins over the sequential step
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
            pc_q <= fetch_pkg::RESET_PC;
        else if (i_redirect)
            pc_q <= i_redirect_pc;
        else if (push.valid)
            pc_q <= pc_q + fetch_pkg::INST_BYTES;
    end

    // Drop flag for a read in flight when the redirect came
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
            discard_q <= 1'b0;
        else if (r_fire)
            discard_q <= 1'b0;
        else if (i_redirect && (state_q != fetch_pkg::IDLE))
            discard_q <= 1'b1;
    end

endmodule

// File: src/fetch_ifs.sv
`timescale 1ns/10ps

// AXI4-Lite read address and read data channels
interface axi_rd_if;
    axi_lite_pkg::axi_addr_t araddr;
    logic                    arvalid;
    logic                    arready;
    fetch_pkg::word_t        rdata;
    axi_lite_pkg::axi_resp_t rresp;
    logic                    rvalid;
    logic                    rready;

    modport master (output araddr, arvalid, rready, input arready, rdata, rresp, rvalid);
    modport slave  (input araddr, arvalid, rready, output arready, rdata, rresp, rvalid);
endinterface

// One fetched entry with its valid/ready pair
interface fetch_entry_if;
    fetch_pkg::pc_t   pc;
    fetch_pkg::word_t ins;
    logic             fault;
    logic             valid;
    logic             ready;

    modport producer (output pc, ins, fault, valid, input ready);
    modport consumer (input pc, ins, fault, valid, output ready);
endinterface

// File: src/axi_lite_pkg.sv
package axi_lite_pkg;

    // ----------------------------------------------------------
    // AXI4-Lite read channel types
    // ----------------------------------------------------------
    localparam int AXI_ADDR_WIDTH = 32;

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [1:0]                axi_resp_t;

    // RRESP codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // Instruction memory geometry and timing
    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 2;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

endpackage

// File: src/fetch_pkg.sv
package fetch_pkg;

    // ----------------------------------------------------------
    // Widths and fixed values of the fetch path
    // ----------------------------------------------------------
    localparam int ISA_WIDTH = 32;

    // Instruction word and byte address of an instruction
    typedef logic [ISA_WIDTH-1:0] word_t;
    typedef logic [ISA_WIDTH-1:0] pc_t;

    // First fetch address after reset
    localparam pc_t RESET_PC = '0;

    // Sequential step, one 32-bit word
    localparam pc_t INST_BYTES = 32'd4;

    // Queue size and pointer width
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // RV32 major opcodes that decode tells apart
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;

    // Retire classes
    typedef enum logic [1:0] {
        JAL,
        OPIMM,
        LOAD_UPPER,
        OTHER
    } inst_class_e;

    // Read master states
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } fetch_state_e;

endpackage
